// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f rv32_core.f --top-module tb_rv32_core -o sim_rv32
	./obj_dir/sim_rv32 | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/fetch_execute_if.sv
`timescale 1ns/100ps

interface fetch_execute_if;

  // Pipeline register, owned by fetch
  rv32_pkg::word_t instr;    // Instruction in execute
  rv32_pkg::word_t pc;       // Its address
  rv32_pkg::word_t pc4;      // Its address plus four, link value
  logic            valid;    // Low for a bubble

  // Controls back from execute
  rv32_pkg::word_t brj_addr; // Taken branch or jump target
  logic            redirect; // Load brj_addr and squash the fetched word
  logic            stall;    // Data memory busy, hold everything

  modport fetch (
    output instr, pc, pc4, valid,
    input  brj_addr, redirect, stall
  );

  modport execute (
    input  instr, pc, pc4, valid,
    output brj_addr, redirect, stall
  );

endinterface

// File: common/rv32_pkg.sv
package rv32_pkg;

  typedef logic [31:0] word_t;   // Data, address and instruction word
  typedef logic [4:0]  reg_idx_t; // Architectural register index

  localparam int    REG_COUNT = 32;       // x0..x31
  localparam word_t RESET_PC  = 32'h0;    // First fetch address

  // Major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_t;

  // ALU operations, coded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_t;

  // Branch conditions, same code as funct3
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_t;

  typedef enum logic {A_RS1, A_PC} a_sel_t;                      // ALU port A source
  typedef enum logic [1:0] {B_RS2, B_IMM_I, B_IMM_S, B_IMM_U} b_sel_t; // ALU port B source
  typedef enum logic [1:0] {W_LOAD, W_PC4, W_ALU} w_sel_t;       // Write-back source

endpackage

// File: execute/alu.sv
`timescale 1ns/100ps

module alu (
  input  rv32_pkg::alu_op_t op,
  input  rv32_pkg::word_t   a,
  input  rv32_pkg::word_t   b,
  output rv32_pkg::word_t   result,
  output logic              equal,
  output logic              less,
  output logic              less_u
);

  logic [4:0] shamt;

  assign shamt  = b[4:0];            // Upper bits ignored, so SRAI funct7 is harmless
  assign equal  = (a == b);
  assign less   = ($signed(a) < $signed(b));
  assign less_u = (a < b);

  always_comb begin
    case (op)
      rv32_pkg::ALU_ADD:  result = a + b;
      rv32_pkg::ALU_SUB:  result = a - b;
      rv32_pkg::ALU_SLL:  result = a << shamt;
      rv32_pkg::ALU_SLT:  result = {31'b0, less};
      rv32_pkg::ALU_SLTU: result = {31'b0, less_u};
      rv32_pkg::ALU_XOR:  result = a ^ b;
      rv32_pkg::ALU_SRL:  result = a >> shamt;
      rv32_pkg::ALU_SRA:  result = $signed(a) >>> shamt;
      rv32_pkg::ALU_OR:   result = a | b;
      rv32_pkg::ALU_AND:  result = a & b;
      default:            result = '0;
    endcase
  end

endmodule

// File: execute/control_unit.sv
`timescale 1ns/100ps

module control_unit (
  input  rv32_pkg::word_t    instr,
  output rv32_pkg::alu_op_t  op,
  output rv32_pkg::a_sel_t   a_sel,
  output rv32_pkg::b_sel_t   b_sel,
  output rv32_pkg::w_sel_t   w_sel,
  output rv32_pkg::branch_t  branch_type,
  output rv32_pkg::reg_idx_t rs1,
  output rv32_pkg::reg_idx_t rs2,
  output rv32_pkg::reg_idx_t rd,
  output rv32_pkg::word_t    imm_i,
  output rv32_pkg::word_t    imm_s,
  output rv32_pkg::word_t    imm_b,
  output rv32_pkg::word_t    imm_u,
  output rv32_pkg::word_t    imm_j,
  output logic               reg_wen,
  output logic               is_branch,
  output logic               is_jal,
  output logic               is_jalr,
  output logic               dren,
  output logic               dwen,
  output logic               is_halt
);

  rv32_pkg::opcode_t opcode;
  logic [2:0]        funct3;

  assign opcode = rv32_pkg::opcode_t'(instr[6:0]); // Values outside the enum fall to default
  assign funct3 = instr[14:12];

  // Raw immediate fields in their final bit positions, upper bits zero
  assign imm_i = {20'b0, instr[31:20]};
  assign imm_s = {20'b0, instr[31:25], instr[11:7]};
  assign imm_b = {19'b0, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {11'b0, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  assign rs2         = instr[24:20];
  assign rd          = instr[11:7];
  assign branch_type = rv32_pkg::branch_t'(funct3);

  always_comb begin
    op        = rv32_pkg::ALU_ADD;  // Address and AUIPC/LUI sums
    a_sel     = rv32_pkg::A_RS1;
    b_sel     = rv32_pkg::B_IMM_I;
    w_sel     = rv32_pkg::W_ALU;
    rs1       = instr[19:15];
    reg_wen   = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    dren      = 1'b0;
    dwen      = 1'b0;
    is_halt   = 1'b0;
    case (opcode)
      rv32_pkg::OPC_OP, rv32_pkg::OPC_OP_IMM: begin
        reg_wen = 1'b1;
        b_sel   = (opcode == rv32_pkg::OPC_OP) ? rv32_pkg::B_RS2 : rv32_pkg::B_IMM_I;
        case (funct3)
          3'b000: op = (opcode == rv32_pkg::OPC_OP && instr[30]) ?
                       rv32_pkg::ALU_SUB : rv32_pkg::ALU_ADD; // No SUBI
          3'b001: op = rv32_pkg::ALU_SLL;
          3'b010: op = rv32_pkg::ALU_SLT;
          3'b011: op = rv32_pkg::ALU_SLTU;
          3'b100: op = rv32_pkg::ALU_XOR;
          3'b101: op = instr[30] ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
          3'b110: op = rv32_pkg::ALU_OR;
          default: op = rv32_pkg::ALU_AND;
        endcase
      end
      rv32_pkg::OPC_LUI: begin
        reg_wen = 1'b1;
        rs1     = '0;               // x0 gives a zero on port A
        b_sel   = rv32_pkg::B_IMM_U;
      end
      rv32_pkg::OPC_AUIPC: begin
        reg_wen = 1'b1;
        a_sel   = rv32_pkg::A_PC;
        b_sel   = rv32_pkg::B_IMM_U;
      end
      rv32_pkg::OPC_JAL: begin
        reg_wen = 1'b1;
        is_jal  = 1'b1;
        w_sel   = rv32_pkg::W_PC4;  // Link
      end
      rv32_pkg::OPC_JALR: begin
        reg_wen = 1'b1;
        is_jalr = 1'b1;             // Target is rs1 + imm from the ALU
        w_sel   = rv32_pkg::W_PC4;
      end
      rv32_pkg::OPC_BRANCH: begin
        is_branch = 1'b1;
        b_sel     = rv32_pkg::B_RS2;  // Flags compare rs1 with rs2
        op        = rv32_pkg::ALU_SUB;
      end
      rv32_pkg::OPC_LOAD: begin
        reg_wen = 1'b1;
        dren    = 1'b1;             // LW only
        w_sel   = rv32_pkg::W_LOAD;
      end
      rv32_pkg::OPC_STORE: begin
        dwen  = 1'b1;               // SW only
        b_sel = rv32_pkg::B_IMM_S;
      end
      rv32_pkg::OPC_SYSTEM: begin
        is_halt = (funct3 == 3'b000); // ECALL
      end
      default: ;                    // Unknown opcode is a no-op
    endcase
  end

endmodule

// File: execute/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
  input  logic                   CLK,
  input  logic                   rst_n,
  fetch_execute_if.execute       fe,
  output rv32_pkg::word_t        dmem_addr,
  output rv32_pkg::word_t        dmem_wdata,
  output logic                   dmem_ren,
  output logic                   dmem_wen,
  input  rv32_pkg::word_t        dmem_rdata,
  input  logic                   dmem_busy,
  output logic                   halt
);

  rv32_pkg::alu_op_t  alu_op;
  rv32_pkg::a_sel_t   a_sel;
  rv32_pkg::b_sel_t   b_sel;
  rv32_pkg::w_sel_t   w_sel;
  rv32_pkg::branch_t  branch_type;
  rv32_pkg::reg_idx_t rs1, rs2, rd;
  rv32_pkg::word_t    imm_i, imm_s, imm_b, imm_u, imm_j;
  logic               reg_wen, is_branch, is_jal, is_jalr, dren, dwen, is_halt;

  rv32_pkg::word_t    rs1_data, rs2_data, wdata;
  rv32_pkg::word_t    alu_a, alu_b, alu_result;
  logic               equal, less, less_u;

  rv32_pkg::word_t    imm_i_ext, imm_s_ext, imm_b_ext, imm_j_ext;
  rv32_pkg::word_t    pc_target;   // JAL or branch target
  logic               br_taken;
  logic               active;      // Valid instruction and core not halted
  logic               mem_stall;
  logic               halt_q;

  control_unit cu (
    .instr(fe.instr), .op(alu_op), .a_sel(a_sel), .b_sel(b_sel), .w_sel(w_sel),
    .branch_type(branch_type), .rs1(rs1), .rs2(rs2), .rd(rd),
    .imm_i(imm_i), .imm_s(imm_s), .imm_b(imm_b), .imm_u(imm_u), .imm_j(imm_j),
    .reg_wen(reg_wen), .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
    .dren(dren), .dwen(dwen), .is_halt(is_halt)
  );

  reg_file rf (
    .CLK(CLK), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data),
    .rs2_data(rs2_data), .rd(rd), .wdata(wdata),
    .wen(reg_wen && active && !mem_stall) // Write at the end of the last busy cycle
  );

  alu alu_i (
    .op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result),
    .equal(equal), .less(less), .less_u(less_u)
  );

  // Sign extension from the top bit of each field
  assign imm_i_ext = {{20{imm_i[11]}}, imm_i[11:0]};
  assign imm_s_ext = {{20{imm_s[11]}}, imm_s[11:0]};
  assign imm_b_ext = {{19{imm_b[12]}}, imm_b[12:0]};
  assign imm_j_ext = {{11{imm_j[20]}}, imm_j[20:0]};

  // Operand muxes
  assign alu_a = (a_sel == rv32_pkg::A_PC) ? fe.pc : rs1_data;

  always_comb begin
    case (b_sel)
      rv32_pkg::B_RS2:   alu_b = rs2_data;
      rv32_pkg::B_IMM_S: alu_b = imm_s_ext;
      rv32_pkg::B_IMM_U: alu_b = imm_u;     // Already in upper position
      default:           alu_b = imm_i_ext;
    endcase
  end

  // Branch condition from the ALU flags
  always_comb begin
    case (branch_type)
      rv32_pkg::BR_BEQ:  br_taken = equal;
      rv32_pkg::BR_BNE:  br_taken = !equal;
      rv32_pkg::BR_BLT:  br_taken = less;
      rv32_pkg::BR_BGE:  br_taken = !less;
      rv32_pkg::BR_BLTU: br_taken = less_u;
      rv32_pkg::BR_BGEU: br_taken = !less_u;
      default:           br_taken = 1'b0; // Reserved funct3
    endcase
  end

  // One adder serves JAL and branches, JALR comes from the ALU
  assign pc_target   = fe.pc + (is_jal ? imm_j_ext : imm_b_ext);
  assign fe.brj_addr = is_jalr ? {alu_result[31:1], 1'b0} : pc_target;
  assign fe.redirect = active && (is_jal || is_jalr || (is_branch && br_taken));

  // Write-back select
  always_comb begin
    case (w_sel)
      rv32_pkg::W_LOAD: wdata = dmem_rdata;  // Taken when busy is low
      rv32_pkg::W_PC4:  wdata = fe.pc4;      // Link value
      default:          wdata = alu_result;
    endcase
  end

  // Data memory, levels held while the instruction sits here
  assign active     = fe.valid && !halt_q;
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;
  assign dmem_ren   = dren && active;
  assign dmem_wen   = dwen && active;
  assign mem_stall  = (dmem_ren || dmem_wen) && dmem_busy;
  assign fe.stall   = mem_stall;

  // Halt is sticky once an ECALL executes
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      halt_q <= 1'b0;
    end else if (active && is_halt) begin
      halt_q <= 1'b1;
    end
  end

  assign halt = halt_q;

endmodule

// File: execute/reg_file.sv
`timescale 1ns/100ps

module reg_file (
  input  logic               CLK,
  input  logic               rst_n,
  input  rv32_pkg::reg_idx_t rs1,
  input  rv32_pkg::reg_idx_t rs2,
  output rv32_pkg::word_t    rs1_data,
  output rv32_pkg::word_t    rs2_data,
  input  rv32_pkg::reg_idx_t rd,
  input  rv32_pkg::word_t    wdata,
  input  logic               wen
);

  rv32_pkg::word_t regs [rv32_pkg::REG_COUNT];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < rv32_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      regs[rd] <= wdata;            // x0 never written
    end
  end

  // Combinational reads, x0 hardwired to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: fetch/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
  input  logic                   CLK,
  input  logic                   rst_n,
  fetch_execute_if.fetch         fe,
  output rv32_pkg::word_t        imem_addr,
  input  rv32_pkg::word_t        imem_rdata,
  input  logic                   halt
);

  rv32_pkg::word_t pc;       // Address being fetched this cycle
  rv32_pkg::word_t pc_plus4; // Sequential next address
  logic            advance;  // Pipeline moves this cycle

  assign imem_addr = pc;     // Instruction memory answers in the same cycle
  assign pc_plus4  = pc + 32'd4;

  // Stall wins over redirect since the stalled instruction is still executing
  assign advance = !fe.stall && !halt;

  // Program counter and valid bit
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pc       <= rv32_pkg::RESET_PC;
      fe.valid <= 1'b0;                 // Nothing fetched yet
    end else if (fe.stall) begin
      pc       <= pc;                   // Back-pressure from data memory
      fe.valid <= fe.valid;
    end else if (halt) begin
      pc       <= pc;                   // Core frozen after ECALL
      fe.valid <= 1'b0;
    end else if (fe.redirect) begin
      pc       <= fe.brj_addr;          // Not-taken guess was wrong
      fe.valid <= 1'b0;                 // One bubble
    end else begin
      pc       <= pc_plus4;
      fe.valid <= 1'b1;
    end
  end

  // Pipeline register payload
  always_ff @(posedge CLK) begin
    if (advance) begin
      fe.instr <= imem_rdata;
      fe.pc    <= pc;
      fe.pc4   <= pc_plus4;           // Kept for the JAL/JALR link
    end
  end

endmodule

// File: rtl/rv32_core.sv
`timescale 1ns/100ps

module rv32_core (
  input  logic            CLK,
  input  logic            rst_n,
  output rv32_pkg::word_t imem_addr,
  input  rv32_pkg::word_t imem_rdata,  // Combinational, same cycle
  output rv32_pkg::word_t dmem_addr,
  output rv32_pkg::word_t dmem_wdata,
  output logic            dmem_ren,
  output logic            dmem_wen,
  input  rv32_pkg::word_t dmem_rdata,
  input  logic            dmem_busy,
  output logic            halt
);

  fetch_execute_if fe_if ();          // Pipeline register and controls

  fetch_stage fetch (
    .CLK(CLK),
    .rst_n(rst_n),
    .fe(fe_if.fetch),
    .imem_addr(imem_addr),
    .imem_rdata(imem_rdata),
    .halt(halt)                       // Freezes the PC
  );

  execute_stage execute (
    .CLK(CLK),
    .rst_n(rst_n),
    .fe(fe_if.execute),
    .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_ren(dmem_ren),
    .dmem_wen(dmem_wen),
    .dmem_rdata(dmem_rdata),
    .dmem_busy(dmem_busy),
    .halt(halt)
  );

endmodule

// File: rv32_core.f
common/rv32_pkg.sv
common/fetch_execute_if.sv
fetch/fetch_stage.sv
execute/alu.sv
execute/reg_file.sv
execute/control_unit.sv
execute/execute_stage.sv
rtl/rv32_core.sv
tb/rv32_core_properties.sv
tb/tb_rv32_core.sv

// File: tb/rv32_core_properties.sv
`timescale 1ns/100ps

module rv32_core_properties (
  input logic            CLK,
  input logic            rst_n,
  input rv32_pkg::word_t imem_addr,
  input rv32_pkg::word_t dmem_addr,
  input rv32_pkg::word_t dmem_wdata,
  input logic            dmem_ren,
  input logic            dmem_wen,
  input logic            dmem_busy,
  input logic            halt
);

  int fail_count = 0;                              // Read by the testbench at the end

  // Access held while memory is busy
  hold_on_busy: assert property (@(posedge CLK) disable iff (!rst_n)
    (dmem_busy && (dmem_ren || dmem_wen)) |=> ($stable(dmem_addr) && $stable(dmem_wdata)
      && $stable(dmem_ren) && $stable(dmem_wen)))
    else begin
      fail_count++;
      $error("Memory request changed while busy");
    end

  one_strobe: assert property (@(posedge CLK) disable iff (!rst_n) !(dmem_ren && dmem_wen))
    else begin
      fail_count++;
      $error("Read and write strobes both high");
    end

  quiet_after_reset: assert property (@(posedge CLK) $rose(rst_n) |-> (!dmem_ren && !dmem_wen
    && !halt))
    else begin
      fail_count++;
      $error("Strobes or halt high right after reset");
    end

  aligned_fetch: assert property (@(posedge CLK) disable iff (!rst_n) imem_addr[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("Fetch address not word aligned");
    end

  halt_sticky: assert property (@(posedge CLK) disable iff (!rst_n) halt |=> halt)
    else begin
      fail_count++;
      $error("Halt dropped");
    end

endmodule

// File: tb/tb_rv32_core.sv
`timescale 1ns/100ps

module tb_rv32_core;

  localparam int          PROG_CYCLES = 80;        // Instructions plus bubbles with margin
  localparam int          BUSY_ALLOW  = 200;       // Extra cycles lost to dmem_busy
  localparam logic [15:0] LFSR_SEED   = 16'd63427;

  logic            CLK = 1'b0;
  logic            rst_n;
  rv32_pkg::word_t imem_addr, imem_rdata;
  rv32_pkg::word_t dmem_addr, dmem_wdata, dmem_rdata;
  logic            dmem_ren, dmem_wen, dmem_busy, halt;

  rv32_pkg::word_t rom [64];                       // Program with ECALL in the unused words
  rv32_pkg::word_t ram [256];
  rv32_pkg::word_t exp_addr[$];                    // Expected stores in program order
  rv32_pkg::word_t exp_data[$];
  logic [15:0]     lfsr;
  int              store_idx   = 0;
  int              value_errs  = 0;
  int              count_errs  = 0;

  rv32_core UUT (.*);

  bind rv32_core rv32_core_properties props (.*);

  always #50 CLK = ~CLK;

  assign imem_rdata = rom[imem_addr[7:2]];         // Combinational instruction memory
  assign dmem_rdata = dmem_ren ? ram[dmem_addr[9:2]] : 32'h0; // Data only on a read strobe

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // Galois taps 16,14,13,11
  endfunction

  // Instruction encoders with ISA field order
  function automatic rv32_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    enc_r = {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rv32_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    enc_i = {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv32_pkg::word_t enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1);
    enc_sw = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic rv32_pkg::word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic rv32_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic expect_store(input rv32_pkg::word_t addr, input rv32_pkg::word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic load_program();
    logic [2:0] f3_taken [6];
    logic [4:0] t_rs1 [6], t_rs2 [6];
    int         p;
    for (int i = 0; i < 64; i++) rom[i] = 32'h0000_0073; // ECALL
    rom[0]  = enc_i(12'd5, 0, 3'b000, 1, 7'b0010011);    // addi x1,x0,5
    rom[1]  = enc_i(-12'sd3, 0, 3'b000, 2, 7'b0010011);  // addi x2,x0,-3
    rom[2]  = enc_r(7'h00, 2, 1, 3'b000, 3);            // add  x3 = 2
    rom[3]  = enc_sw(12'd0, 3, 0);
    rom[4]  = enc_r(7'h20, 2, 1, 3'b000, 4);            // sub  x4 = 8
    rom[5]  = enc_sw(12'd4, 4, 0);
    rom[6]  = enc_r(7'h00, 1, 2, 3'b010, 5);            // slt  -3 < 5
    rom[7]  = enc_r(7'h00, 1, 2, 3'b011, 6);            // sltu big < 5 is false
    rom[8]  = enc_r(7'h00, 2, 1, 3'b100, 7);            // xor
    rom[9]  = enc_sw(12'd8, 5, 0);
    rom[10] = enc_sw(12'd12, 6, 0);
    rom[11] = enc_sw(12'd16, 7, 0);
    rom[12] = enc_r(7'h00, 1, 1, 3'b001, 8);            // sll  5 << 5
    rom[13] = enc_i(12'h401, 2, 3'b101, 9, 7'b0010011);  // srai x2,1
    rom[14] = enc_i(12'd28, 2, 3'b101, 10, 7'b0010011);  // srli x2,28
    rom[15] = enc_r(7'h00, 2, 1, 3'b110, 11);           // or
    rom[16] = enc_i(12'h0FF, 2, 3'b111, 12, 7'b0010011); // andi
    for (int i = 0; i < 5; i++) rom[17 + i] = enc_sw(12'(20 + 4 * i), 5'(8 + i), 0);
    rom[22] = {20'h12345, 5'd13, 7'b0110111};            // lui
    rom[23] = {20'h00001, 5'd14, 7'b0010111};            // auipc at 0x5C
    rom[24] = enc_i(12'd7, 0, 3'b000, 0, 7'b0010011);    // Write to x0 is dropped
    rom[25] = enc_sw(12'd40, 13, 0);
    rom[26] = enc_sw(12'd44, 14, 0);
    rom[27] = enc_sw(12'd48, 0, 0);
    // Each branch type taken over a stray store and then not taken
    f3_taken = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    t_rs1    = '{5'd1, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
    t_rs2    = '{5'd1, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1};
    p = 28;
    for (int k = 0; k < 6; k++) begin
      rom[p]     = enc_b(13'd8, t_rs2[k], t_rs1[k], f3_taken[k]);
      rom[p + 1] = enc_sw(12'd252, 1, 0);                // Must be skipped
      // The not-taken twin swaps the operands for the ordered compares
      if (k == 0) begin
        rom[p + 2] = enc_b(13'd8, 2, 1, 3'b000);         // beq x1 against x2
      end else if (k == 1) begin
        rom[p + 2] = enc_b(13'd8, 1, 1, 3'b001);         // bne x1 against itself
      end else begin
        rom[p + 2] = enc_b(13'd8, t_rs1[k], t_rs2[k], f3_taken[k]);
      end
      rom[p + 3] = enc_sw(12'(52 + 4 * k), 1, 0);
      p += 4;
    end
    rom[52] = enc_j(21'd8, 15);                          // jal x15 to 0xD8
    rom[53] = enc_sw(12'd252, 1, 0);
    rom[54] = enc_sw(12'd76, 15, 0);
    rom[55] = enc_i(12'd232, 0, 3'b000, 16, 7'b0010011);
    rom[56] = enc_i(12'd1, 16, 3'b000, 17, 7'b1100111); // jalr to 233 lands on 232
    rom[57] = enc_sw(12'd252, 1, 0);
    rom[58] = enc_sw(12'd80, 17, 0);
    rom[59] = enc_sw(12'd84, 13, 0);
    rom[60] = enc_i(12'd84, 0, 3'b010, 18, 7'b0000011);  // lw x18 from the store above
    rom[61] = enc_sw(12'd88, 18, 0);
    rom[63] = enc_sw(12'd92, 1, 0);                      // Never reached after ECALL
  endtask

  task automatic load_expected();
    expect_store(0, 2);
    expect_store(4, 8);
    expect_store(8, 1);
    expect_store(12, 0);
    expect_store(16, 32'hFFFF_FFF8);
    expect_store(20, 32'hA0);
    expect_store(24, 32'hFFFF_FFFE);
    expect_store(28, 32'hF);
    expect_store(32, 32'hFFFF_FFFD);
    expect_store(36, 32'hFD);
    expect_store(40, 32'h1234_5000);
    expect_store(44, 32'h105C);                        // 0x5C + 0x1000
    expect_store(48, 0);
    for (int k = 0; k < 6; k++) expect_store(52 + 4 * k, 5);
    expect_store(76, 32'hD4);                          // jal link
    expect_store(80, 32'hE4);                          // jalr link
    expect_store(84, 32'h1234_5000);
    expect_store(88, 32'h1234_5000);                   // Loaded back
  endtask

  // Busy from one LFSR bit per cycle
  always @(posedge CLK) begin
    dmem_busy <= lfsr[0];
    lfsr      <= lfsr_next(lfsr);
  end

  // Data RAM write and store check on completion
  always @(posedge CLK) begin
    if (rst_n && dmem_wen && !dmem_busy) begin
      ram[dmem_addr[9:2]] <= dmem_wdata;
      if (store_idx < exp_addr.size()) begin
        assert (dmem_addr == exp_addr[store_idx] && dmem_wdata == exp_data[store_idx])
        else begin
          value_errs++;
          $display("ERROR at %0t ns: store %0d wrote %h to %h, expected %h to %h", $time,
                   store_idx, dmem_wdata, dmem_addr, exp_data[store_idx], exp_addr[store_idx]);
        end
      end else begin
        value_errs++;
        $display("ERROR at %0t ns: unexpected store of %h to %h", $time, dmem_wdata, dmem_addr);
      end
      store_idx++;
    end
  end

  initial begin
    rst_n     <= 1'b0;
    dmem_busy <= 1'b0;
    lfsr      <= LFSR_SEED;
    for (int i = 0; i < 256; i++) ram[i] <= 32'hC3A5_0000 ^ {i[7:0], 8'h00, ~i[7:0], i[7:0]};
    load_program();
    load_expected();
    repeat (8) @(posedge CLK);
    rst_n <= 1'b1;
    while (!halt) @(posedge CLK);                      // Watchdog guards this wait
    repeat (6) @(posedge CLK);                         // Room for a stray store after halt
    if (store_idx != exp_addr.size()) begin
      count_errs++;
      $display("ERROR at %0t ns: the program made %0d stores where %0d were expected", $time,
               store_idx, exp_addr.size());
    end
    $display("Errors: %0d wrong stores, %0d store count, %0d assertion failures",
             value_errs, count_errs, UUT.props.fail_count);
    if (value_errs == 0 && count_errs == 0 && UUT.props.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((4 * PROG_CYCLES + BUSY_ALLOW + 8) * 100);
    $display("Timeout: the core did not reach halt in time");
    $display("Testbench failed");
    $finish;
  end

endmodule
